/* cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define XLEN        32
`define REG_ADDR_W  5

// CSR numbers
`define CSR_ADDR_W     14
`define CSR_CRMD       14'h000
`define CSR_PRMD       14'h001
`define CSR_ESTAT      14'h005
`define CSR_ERA        14'h006
`define CSR_EENTRY     14'h00C
`define CSR_TCFG       14'h041
`define CSR_TICLR      14'h044
`define CSR_TLBRENTRY  14'h088

`define ECODE_W     6
`define ECODE_INT   6'h00
`define ECODE_TLBR  6'h3F

`define INT_LINES     8   // Hardware interrupt lines in ESTAT.IS[9:2]
`define TIMER_IS_BIT  11

`define EENTRY_RESET     32'h1C00_8000
`define TLBRENTRY_RESET  32'h1C00_C000

`endif

/* cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        NORMAL,
        BRANCH,
        EXCP,
        ERTN,
        IDLE,
        CSRWR
    } commit_kind_e;

    typedef struct packed {
        logic                     valid;
        commit_kind_e             kind;
        logic [`XLEN-1:0]         pc;
        logic                     rf_we;
        logic [`REG_ADDR_W-1:0]   rf_waddr;
        logic [`XLEN-1:0]         rf_wdata;  // Also CSR write data
        logic [`XLEN-1:0]         target;
        logic [`ECODE_W-1:0]      ecode;
        logic [`CSR_ADDR_W-1:0]   csr_addr;
    } commit_slot_t;

    typedef struct packed {
        logic                     valid;
        commit_kind_e             kind;
        logic [`XLEN-1:0]         pc;
        logic [`XLEN-1:0]         target;
        logic [`ECODE_W-1:0]      ecode;
        logic                     csr_we;
        logic [`CSR_ADDR_W-1:0]   csr_addr;
        logic [`XLEN-1:0]         csr_wdata;
    } trap_event_t;

    // Debug trace that doubles as a regfile write port
    typedef struct packed {
        logic [`XLEN-1:0]         pc;
        logic                     wen;
        logic [`REG_ADDR_W-1:0]   wnum;
        logic [`XLEN-1:0]         wdata;
    } trace_t;

    typedef struct packed {
        logic [28:0] rest;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rest;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef union packed {
        crmd_t       crmd;
        prmd_t       prmd;
        tcfg_t       tcfg;
        logic [31:0] raw;
    } csr_word_u;

    typedef struct packed {
        crmd_t            crmd;
        prmd_t            prmd;
        logic [`XLEN-1:0] era;
        logic [`XLEN-1:0] eentry;
        logic [`XLEN-1:0] tlbrentry;
    } csr_state_t;

endpackage

/* commit_regfile.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module commit_regfile (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  cpu_pkg::trace_t [1:0]             wr_i,
    input  logic [1:0][`REG_ADDR_W-1:0]       raddr_i,
    output logic [1:0][`XLEN-1:0]             rdata_o
);

    logic [`XLEN-1:0] regs [1:31];  // r0 has no storage

    always_ff @(posedge clk) begin
        for (int i = 1; i < 32; i++) begin
            if (rst_n_i && wr_i[1].wen && wr_i[1].wnum == `REG_ADDR_W'(i)) begin
                regs[i] <= wr_i[1].wdata;  // Younger slot wins
            end else if (rst_n_i && wr_i[0].wen && wr_i[0].wnum == `REG_ADDR_W'(i)) begin
                regs[i] <= wr_i[0].wdata;
            end
        end
    end

    // No write bypass
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

/* commit_arbiter.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module commit_arbiter (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  cpu_pkg::commit_slot_t [1:0]   commit_i,
    input  logic                          idle_i,
    output cpu_pkg::trace_t [1:0]         rf_wr_o,
    output cpu_pkg::trap_event_t          event_o,
    output cpu_pkg::trace_t [1:0]         trace_o
);

    logic [1:0] take;

    function automatic cpu_pkg::trap_event_t to_event(input cpu_pkg::commit_slot_t s);
        cpu_pkg::trap_event_t e;
        e.valid     = 1'b1;
        e.kind      = s.kind;
        e.pc        = s.pc;
        e.target    = s.target;
        e.ecode     = s.ecode;
        e.csr_we    = (s.kind == cpu_pkg::CSRWR);
        e.csr_addr  = s.csr_addr;
        e.csr_wdata = s.rf_wdata;
        return e;
    endfunction

    // Younger slot only follows a plain older one
    assign take[0] = !idle_i && commit_i[0].valid;
    assign take[1] = !idle_i && commit_i[1].valid
                     && (!commit_i[0].valid || commit_i[0].kind == cpu_pkg::NORMAL);

    always_comb begin
        event_o = '0;
        if (take[0] && commit_i[0].kind != cpu_pkg::NORMAL) begin
            event_o = to_event(commit_i[0]);
        end else if (take[1] && commit_i[1].kind != cpu_pkg::NORMAL) begin
            event_o = to_event(commit_i[1]);
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_wr_o[i].pc    = commit_i[i].pc;
            rf_wr_o[i].wen   = take[i] && commit_i[i].rf_we
                               && (commit_i[i].kind == cpu_pkg::NORMAL
                                   || commit_i[i].kind == cpu_pkg::BRANCH);
            rf_wr_o[i].wnum  = commit_i[i].rf_waddr;
            rf_wr_o[i].wdata = commit_i[i].rf_wdata;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            trace_o[i] <= rf_wr_o[i];
            if (!rst_n_i) begin
                trace_o[i].wen <= 1'b0;
            end
        end
    end

endmodule

/* trap_csr.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module trap_csr (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  cpu_pkg::trap_event_t         cmd_i,
    input  cpu_pkg::trap_event_t         int_entry_i,
    input  logic [`INT_LINES-1:0]        intrpt_i,
    input  logic                         timer_pending_i,
    input  logic [`CSR_ADDR_W-1:0]       raddr_i,
    output logic [`XLEN-1:0]             rdata_o,
    output cpu_pkg::csr_state_t          state_o,
    output logic                         int_pending_o,
    output logic                         tcfg_we_o,
    output cpu_pkg::tcfg_t               tcfg_o,
    output logic                         ticlr_o
);

    cpu_pkg::crmd_t      crmd_q;
    cpu_pkg::prmd_t      prmd_q;
    cpu_pkg::tcfg_t      tcfg_q;
    logic [`ECODE_W-1:0] ecode_q;
    logic [`XLEN-1:0]    era_q;
    logic [`XLEN-1:0]    eentry_q;
    logic [`XLEN-1:0]    tlbrentry_q;
    logic [12:0]         estat_is;
    cpu_pkg::csr_word_u  wr_word;
    cpu_pkg::trap_event_t excp_src;
    logic                take_excp;
    logic                take_ertn;
    logic                csr_wr;

    assign wr_word.raw = cmd_i.csr_wdata;
    assign csr_wr      = cmd_i.valid && cmd_i.csr_we;
    assign take_excp   = (cmd_i.valid && cmd_i.kind == cpu_pkg::EXCP) || int_entry_i.valid;
    assign take_ertn   = cmd_i.valid && cmd_i.kind == cpu_pkg::ERTN;
    assign excp_src    = int_entry_i.valid ? int_entry_i : cmd_i;

    // Read-only IS follows the lines
    always_comb begin
        estat_is = '0;
        estat_is[`INT_LINES+1:2]   = intrpt_i;
        estat_is[`TIMER_IS_BIT]    = timer_pending_i;
    end

    assign int_pending_o = crmd_q.ie && (|estat_is);

    assign tcfg_we_o = csr_wr && cmd_i.csr_addr == `CSR_TCFG;
    assign tcfg_o    = wr_word.tcfg;
    assign ticlr_o   = csr_wr && cmd_i.csr_addr == `CSR_TICLR && cmd_i.csr_wdata[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_q      <= '0;
            prmd_q      <= '0;
            tcfg_q      <= '0;
            ecode_q     <= '0;
            era_q       <= '0;
            eentry_q    <= `EENTRY_RESET;
            tlbrentry_q <= `TLBRENTRY_RESET;
        end else if (take_excp) begin
            prmd_q.pplv <= crmd_q.plv;
            prmd_q.pie  <= crmd_q.ie;
            crmd_q.plv  <= 2'd0;
            crmd_q.ie   <= 1'b0;
            era_q       <= excp_src.pc;
            ecode_q     <= excp_src.ecode;
        end else if (take_ertn) begin
            crmd_q.plv <= prmd_q.pplv;
            crmd_q.ie  <= prmd_q.pie;
        end else if (csr_wr) begin
            case (cmd_i.csr_addr)
                `CSR_CRMD: begin
                    crmd_q.plv <= wr_word.crmd.plv;
                    crmd_q.ie  <= wr_word.crmd.ie;
                end
                `CSR_PRMD: begin
                    prmd_q.pplv <= wr_word.prmd.pplv;
                    prmd_q.pie  <= wr_word.prmd.pie;
                end
                `CSR_ERA:       era_q       <= wr_word.raw;
                `CSR_EENTRY:    eentry_q    <= wr_word.raw;
                `CSR_TLBRENTRY: tlbrentry_q <= wr_word.raw;
                `CSR_TCFG:      tcfg_q      <= wr_word.tcfg;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            `CSR_CRMD:      rdata_o = crmd_q;
            `CSR_PRMD:      rdata_o = prmd_q;
            `CSR_ESTAT:     rdata_o = {10'd0, ecode_q, 3'd0, estat_is};
            `CSR_ERA:       rdata_o = era_q;
            `CSR_EENTRY:    rdata_o = eentry_q;
            `CSR_TLBRENTRY: rdata_o = tlbrentry_q;
            `CSR_TCFG:      rdata_o = tcfg_q;
            default:        rdata_o = '0;  // TICLR reads zero
        endcase
    end

    assign state_o.crmd      = crmd_q;
    assign state_o.prmd      = prmd_q;
    assign state_o.era       = era_q;
    assign state_o.eentry    = eentry_q;
    assign state_o.tlbrentry = tlbrentry_q;

endmodule

/* stable_timer.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module stable_timer (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            tcfg_we_i,
    input  cpu_pkg::tcfg_t  tcfg_i,
    input  logic            ticlr_i,
    output logic            pending_o
);

    logic              running;
    logic              periodic;
    logic [29:0]       initval;
    logic [`XLEN-1:0]  count;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            running   <= 1'b0;
            periodic  <= 1'b0;
            pending_o <= 1'b0;
        end else begin
            if (ticlr_i) begin
                pending_o <= 1'b0;
            end
            if (tcfg_we_i) begin
                running  <= tcfg_i.en;
                periodic <= tcfg_i.periodic;
            end else if (running && count == '0) begin
                pending_o <= 1'b1;  // Expiry beats a clear
                running   <= periodic;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_we_i) begin
            initval <= tcfg_i.initval;
            count   <= {tcfg_i.initval, 2'b00};
        end else if (running) begin
            if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                count <= {initval, 2'b00};  // Reload is unused when one-shot
            end
        end
    end

endmodule

/* redirect_fsm.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module redirect_fsm (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  cpu_pkg::trap_event_t   event_i,
    input  cpu_pkg::csr_state_t    csr_i,
    input  logic                   int_pending_i,
    output logic                   flush_o,
    output logic [`XLEN-1:0]       redirect_pc_o,
    output logic                   idle_o,
    output cpu_pkg::trap_event_t   int_entry_o
);

    logic             idle_q;
    logic [`XLEN-1:0] idle_pc;
    logic             int_take;
    logic             flush_d;
    logic [`XLEN-1:0] pc_d;

    assign idle_o   = idle_q;
    assign int_take = idle_q && int_pending_i;  // Only seen in idle
    assign flush_d  = event_i.valid && (event_i.kind == cpu_pkg::BRANCH
                                        || event_i.kind == cpu_pkg::EXCP
                                        || event_i.kind == cpu_pkg::ERTN);

    // Branch, refill, exception, return
    always_comb begin
        if (event_i.kind == cpu_pkg::BRANCH) begin
            pc_d = event_i.target;
        end else if (event_i.kind == cpu_pkg::EXCP && event_i.ecode == `ECODE_TLBR) begin
            pc_d = csr_i.tlbrentry;
        end else if (event_i.kind == cpu_pkg::EXCP) begin
            pc_d = csr_i.eentry;
        end else begin
            pc_d = csr_i.era;
        end
    end

    // Interrupt entry handed to the CSRs as an exception
    always_comb begin
        int_entry_o       = '0;
        int_entry_o.valid = int_take;
        int_entry_o.kind  = cpu_pkg::EXCP;
        int_entry_o.pc    = idle_pc + `XLEN'd4;
        int_entry_o.ecode = `ECODE_INT;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            idle_q  <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            flush_o <= flush_d || int_take;
            if (event_i.valid && event_i.kind == cpu_pkg::IDLE) begin
                idle_q <= 1'b1;
            end else if (int_take) begin
                idle_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc_o <= int_take ? csr_i.eentry : pc_d;
        if (event_i.valid && event_i.kind == cpu_pkg::IDLE) begin
            idle_pc <= event_i.pc;
        end
    end

endmodule

/* cpu_commit_top.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_commit_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  cpu_pkg::commit_slot_t [1:0]   commit_i,
    input  logic [`INT_LINES-1:0]         intrpt_i,
    input  logic [1:0][`REG_ADDR_W-1:0]   rf_raddr_i,
    input  logic [`CSR_ADDR_W-1:0]        csr_raddr_i,
    output logic [1:0][`XLEN-1:0]         rf_rdata_o,
    output logic [`XLEN-1:0]              csr_rdata_o,
    output logic                          flush_o,
    output logic [`XLEN-1:0]              redirect_pc_o,
    output cpu_pkg::trace_t [1:0]         trace_o
);

    cpu_pkg::trace_t [1:0]   rf_wr;
    cpu_pkg::trap_event_t    trap_event;
    cpu_pkg::trap_event_t    int_entry;
    cpu_pkg::csr_state_t     csr_state;
    cpu_pkg::tcfg_t          tcfg;
    logic                    idle;
    logic                    int_pending;
    logic                    tcfg_we;
    logic                    ticlr;
    logic                    timer_pending;

    commit_arbiter u_commit_arbiter (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .commit_i (commit_i),
        .idle_i   (idle),
        .rf_wr_o  (rf_wr),
        .event_o  (trap_event),
        .trace_o  (trace_o)
    );

    commit_regfile u_commit_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wr_i     (rf_wr),
        .raddr_i  (rf_raddr_i),
        .rdata_o  (rf_rdata_o)
    );

    trap_csr u_trap_csr (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .cmd_i           (trap_event),
        .int_entry_i     (int_entry),
        .intrpt_i        (intrpt_i),
        .timer_pending_i (timer_pending),
        .raddr_i         (csr_raddr_i),
        .rdata_o         (csr_rdata_o),
        .state_o         (csr_state),
        .int_pending_o   (int_pending),
        .tcfg_we_o       (tcfg_we),
        .tcfg_o          (tcfg),
        .ticlr_o         (ticlr)
    );

    stable_timer u_stable_timer (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .tcfg_we_i (tcfg_we),
        .tcfg_i    (tcfg),
        .ticlr_i   (ticlr),
        .pending_o (timer_pending)
    );

    redirect_fsm u_redirect_fsm (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .event_i       (trap_event),
        .csr_i         (csr_state),
        .int_pending_i (int_pending),
        .flush_o       (flush_o),
        .redirect_pc_o (redirect_pc_o),
        .idle_o        (idle),
        .int_entry_o   (int_entry)
    );

endmodule

/* cpu_commit_properties.sv */
`timescale 1ns/1ns

module cpu_commit_properties (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    idle_i,
    input  cpu_pkg::trace_t [1:0]   trace_i
);

    // Redirect is a single-cycle pulse
    flush_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !flush_i)
        else $error("flush_o stayed high for two cycles");

    trace_reset: assert property (@(posedge clk)
        !rst_n_i |=> (!trace_i[0].wen && !trace_i[1].wen))
        else $error("trace write enable set right after reset");

    idle_no_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        idle_i |-> !flush_i)
        else $error("flush_o high while idle");

endmodule

bind cpu_commit_top cpu_commit_properties u_commit_properties (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (flush_o),
    .idle_i  (idle),
    .trace_i (trace_o)
);

/* tb_cpu_commit.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_cpu_commit;

    localparam int RESET_CYCLES   = 5;
    localparam int TEST_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    logic                          clk;
    logic                          rst_n;
    cpu_pkg::commit_slot_t [1:0]   commit;
    logic [`INT_LINES-1:0]         intrpt;
    logic [1:0][`REG_ADDR_W-1:0]   rf_raddr;
    logic [`CSR_ADDR_W-1:0]        csr_raddr;
    logic [1:0][`XLEN-1:0]         rf_rdata;
    logic [`XLEN-1:0]              csr_rdata;
    logic                          flush;
    logic [`XLEN-1:0]              redirect_pc;
    cpu_pkg::trace_t [1:0]         trace;

    // Reference model
    logic [`XLEN-1:0]       m_regs [0:31];
    logic [31:0]            m_written;
    cpu_pkg::crmd_t         m_crmd;
    cpu_pkg::prmd_t         m_prmd;
    cpu_pkg::tcfg_t         m_tcfg;
    logic [`XLEN-1:0]       m_era;
    logic [`XLEN-1:0]       m_eentry;
    logic [`XLEN-1:0]       m_tlbrentry;
    logic [`ECODE_W-1:0]    m_ecode;
    logic                   m_idle;
    logic [`XLEN-1:0]       m_idle_pc;
    logic                   t_running;
    logic                   t_periodic;
    logic                   t_pending;
    logic [29:0]            t_initval;
    logic [`XLEN-1:0]       t_count;
    cpu_pkg::trace_t [1:0]  exp_trace;
    logic                   exp_flush;
    logic [`XLEN-1:0]       exp_pc;
    int                     cycle_count;

    cpu_commit_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .commit_i      (commit),
        .intrpt_i      (intrpt),
        .rf_raddr_i    (rf_raddr),
        .csr_raddr_i   (csr_raddr),
        .rf_rdata_o    (rf_rdata),
        .csr_rdata_o   (csr_rdata),
        .flush_o       (flush),
        .redirect_pc_o (redirect_pc),
        .trace_o       (trace)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "first mismatch");
    endtask

    task automatic check_trace(input cpu_pkg::trace_t got, input cpu_pkg::trace_t want,
                               input int slot);
        if (got !== want) begin
            report_mismatch($sformatf(
                "trace %0d pc=%h wen=%b r%0d=%h, expected pc=%h wen=%b r%0d=%h",
                slot, got.pc, got.wen, got.wnum, got.wdata,
                want.pc, want.wen, want.wnum, want.wdata));
        end
    endtask

    task automatic check_redirect(input logic got_flush, input logic [`XLEN-1:0] got_pc,
                                  input logic want_flush, input logic [`XLEN-1:0] want_pc);
        if (got_flush !== want_flush) begin
            report_mismatch($sformatf("flush is %b, expected %b", got_flush, want_flush));
        end else if (want_flush && got_pc !== want_pc) begin
            report_mismatch($sformatf("redirect pc is %h, expected %h", got_pc, want_pc));
        end
    endtask

    task automatic check_word(input string what, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] want);
        if (got !== want) begin
            report_mismatch($sformatf("%s reads %h, expected %h", what, got, want));
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_written   = 32'h1;  // r0 is always known
        m_crmd      = '0;
        m_prmd      = '0;
        m_tcfg      = '0;
        m_era       = '0;
        m_eentry    = `EENTRY_RESET;
        m_tlbrentry = `TLBRENTRY_RESET;
        m_ecode     = '0;
        m_idle      = 1'b0;
        m_idle_pc   = '0;
        t_running   = 1'b0;
        t_periodic  = 1'b0;
        t_pending   = 1'b0;
        t_initval   = '0;
        t_count     = '0;
        exp_trace   = '0;
        exp_flush   = 1'b0;
        exp_pc      = '0;
    endtask

    // Write port seen by the regfile and the trace
    function automatic cpu_pkg::trace_t expected_write(input cpu_pkg::commit_slot_t s,
                                                       input logic taken);
        cpu_pkg::trace_t t;
        t.pc    = s.pc;
        t.wen   = taken && s.rf_we
                  && (s.kind == cpu_pkg::NORMAL || s.kind == cpu_pkg::BRANCH);
        t.wnum  = s.rf_waddr;
        t.wdata = s.rf_wdata;
        return t;
    endfunction

    function automatic logic [`XLEN-1:0] expected_csr(input logic [`CSR_ADDR_W-1:0] addr);
        logic [12:0] is_bits;
        is_bits = '0;
        is_bits[`INT_LINES+1:2]  = intrpt;
        is_bits[`TIMER_IS_BIT]   = t_pending;
        case (addr)
            `CSR_CRMD:      return m_crmd;
            `CSR_PRMD:      return m_prmd;
            `CSR_ESTAT:     return {10'd0, m_ecode, 3'd0, is_bits};
            `CSR_ERA:       return m_era;
            `CSR_EENTRY:    return m_eentry;
            `CSR_TLBRENTRY: return m_tlbrentry;
            `CSR_TCFG:      return m_tcfg;
            default:        return '0;
        endcase
    endfunction

    function automatic logic [`CSR_ADDR_W-1:0] pick_csr_addr();
        case ($urandom % 8)
            0:       return `CSR_CRMD;
            1:       return `CSR_PRMD;
            2:       return `CSR_ESTAT;
            3:       return `CSR_ERA;
            4:       return `CSR_EENTRY;
            5:       return `CSR_TLBRENTRY;
            6:       return `CSR_TCFG;
            default: return `CSR_TICLR;
        endcase
    endfunction

    function automatic cpu_pkg::commit_slot_t random_slot();
        cpu_pkg::commit_slot_t s;
        cpu_pkg::tcfg_t        t;
        int unsigned           r;
        s          = '0;
        r          = $urandom % 100;
        s.valid    = ($urandom % 8) != 0;
        s.pc       = $urandom & 32'hFFFF_FFFC;
        s.rf_we    = ($urandom % 4) != 0;
        s.rf_waddr = `REG_ADDR_W'($urandom % 8);  // Few registers, many collisions
        s.rf_wdata = $urandom;
        s.target   = $urandom & 32'hFFFF_FFFC;
        s.ecode    = ($urandom % 2 == 0) ? `ECODE_TLBR : `ECODE_W'($urandom % 62 + 1);
        s.csr_addr = pick_csr_addr();
        if (r < 78) begin
            s.kind = cpu_pkg::NORMAL;
        end else if (r < 82) begin
            s.kind = cpu_pkg::BRANCH;
        end else if (r < 85) begin
            s.kind = cpu_pkg::EXCP;
        end else if (r < 88) begin
            s.kind = cpu_pkg::ERTN;
        end else if (r < 96) begin
            s.kind = cpu_pkg::CSRWR;
        end else begin
            s.kind = cpu_pkg::IDLE;
        end
        // Without CRMD.IE an idle never wakes, so set IE first
        if (s.kind == cpu_pkg::IDLE && !m_crmd.ie) begin
            s.kind     = cpu_pkg::CSRWR;
            s.csr_addr = `CSR_CRMD;
            s.rf_wdata = $urandom | 32'h4;
        end
        if (s.kind == cpu_pkg::CSRWR && s.csr_addr == `CSR_TCFG) begin
            t.initval  = 30'($urandom % 12 + 1);
            t.periodic = 1'($urandom % 2);
            t.en       = ($urandom % 4) != 0;
            s.rf_wdata = t;
        end
        if (s.kind == cpu_pkg::CSRWR && s.csr_addr == `CSR_TICLR) begin
            s.rf_wdata = 32'($urandom % 2);
        end
        return s;
    endfunction

    task automatic drive_stimulus();
        cpu_pkg::commit_slot_t [1:0] next;
        next[0] = random_slot();
        next[1] = random_slot();
        if (exp_flush) begin  // Nothing commits behind a flush
            next[0].valid = 1'b0;
            next[1].valid = 1'b0;
        end
        commit      <= next;
        intrpt      <= (m_idle && $urandom % 6 == 0) ? `INT_LINES'($urandom) : '0;
        rf_raddr[0] <= `REG_ADDR_W'($urandom % 8);
        rf_raddr[1] <= `REG_ADDR_W'($urandom % 8);
        csr_raddr   <= pick_csr_addr();
    endtask

    // One rising edge of the model, using the inputs of the cycle before
    task automatic step_model();
        cpu_pkg::commit_slot_t [1:0] c;
        cpu_pkg::commit_slot_t       ev;
        cpu_pkg::csr_word_u          w;
        logic [1:0]                  take;
        logic                        has_ev;
        logic                        int_take;
        logic                        tcfg_we;
        logic                        ticlr;
        c       = commit;
        take[0] = !m_idle && c[0].valid;
        take[1] = !m_idle && c[1].valid && (!c[0].valid || c[0].kind == cpu_pkg::NORMAL);
        has_ev  = 1'b0;
        ev      = '0;
        if (take[0] && c[0].kind != cpu_pkg::NORMAL) begin
            has_ev = 1'b1;
            ev     = c[0];
        end else if (take[1] && c[1].kind != cpu_pkg::NORMAL) begin
            has_ev = 1'b1;
            ev     = c[1];
        end
        int_take = m_idle && m_crmd.ie && ((|intrpt) || t_pending);

        for (int i = 0; i < 2; i++) begin
            exp_trace[i] = expected_write(c[i], take[i]);
            if (exp_trace[i].wen && exp_trace[i].wnum != '0) begin  // Slot 1 last
                m_regs[exp_trace[i].wnum]    = exp_trace[i].wdata;
                m_written[exp_trace[i].wnum] = 1'b1;
            end
        end

        exp_flush = int_take || (has_ev && (ev.kind == cpu_pkg::BRANCH
                                            || ev.kind == cpu_pkg::EXCP
                                            || ev.kind == cpu_pkg::ERTN));
        if (int_take) begin
            exp_pc = m_eentry;
        end else if (ev.kind == cpu_pkg::BRANCH) begin
            exp_pc = ev.target;
        end else if (ev.kind == cpu_pkg::EXCP) begin
            exp_pc = (ev.ecode == `ECODE_TLBR) ? m_tlbrentry : m_eentry;
        end else begin
            exp_pc = m_era;
        end

        w.raw   = ev.rf_wdata;
        tcfg_we = has_ev && ev.kind == cpu_pkg::CSRWR && ev.csr_addr == `CSR_TCFG;
        ticlr   = has_ev && ev.kind == cpu_pkg::CSRWR && ev.csr_addr == `CSR_TICLR
                  && ev.rf_wdata[0];
        if (int_take || (has_ev && ev.kind == cpu_pkg::EXCP)) begin
            m_prmd.pplv = m_crmd.plv;
            m_prmd.pie  = m_crmd.ie;
            m_crmd.plv  = 2'd0;
            m_crmd.ie   = 1'b0;
            m_era       = int_take ? m_idle_pc + 32'd4 : ev.pc;
            m_ecode     = int_take ? `ECODE_INT : ev.ecode;
        end else if (has_ev && ev.kind == cpu_pkg::ERTN) begin
            m_crmd.plv = m_prmd.pplv;
            m_crmd.ie  = m_prmd.pie;
        end else if (has_ev && ev.kind == cpu_pkg::CSRWR) begin
            case (ev.csr_addr)
                `CSR_CRMD: begin
                    m_crmd.plv = w.crmd.plv;
                    m_crmd.ie  = w.crmd.ie;
                end
                `CSR_PRMD: begin
                    m_prmd.pplv = w.prmd.pplv;
                    m_prmd.pie  = w.prmd.pie;
                end
                `CSR_ERA:       m_era       = w.raw;
                `CSR_EENTRY:    m_eentry    = w.raw;
                `CSR_TLBRENTRY: m_tlbrentry = w.raw;
                `CSR_TCFG:      m_tcfg      = w.tcfg;
                default: ;
            endcase
        end

        // Timer expiry wins over a clear on the same edge
        if (ticlr) begin
            t_pending = 1'b0;
        end
        if (tcfg_we) begin
            t_running  = w.tcfg.en;
            t_periodic = w.tcfg.periodic;
            t_initval  = w.tcfg.initval;
            t_count    = {w.tcfg.initval, 2'b00};
        end else if (t_running) begin
            if (t_count == '0) begin
                t_pending = 1'b1;
                t_running = t_periodic;
                t_count   = {t_initval, 2'b00};
            end else begin
                t_count = t_count - 32'd1;
            end
        end

        if (has_ev && ev.kind == cpu_pkg::IDLE) begin
            m_idle    = 1'b1;
            m_idle_pc = ev.pc;
        end else if (int_take) begin
            m_idle = 1'b0;
        end
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < 2; i++) begin
            check_trace(trace[i], exp_trace[i], i);
        end
        check_redirect(flush, redirect_pc, exp_flush, exp_pc);
        for (int p = 0; p < 2; p++) begin
            if (m_written[rf_raddr[p]]) begin  // Registers have no reset value
                check_word($sformatf("r%0d", rf_raddr[p]), rf_rdata[p], m_regs[rf_raddr[p]]);
            end
        end
        check_word($sformatf("csr 0x%0h", csr_raddr), csr_rdata, expected_csr(csr_raddr));
    endtask

    initial begin
        void'($urandom(50482));
        rst_n     <= 1'b0;
        commit    <= '0;
        intrpt    <= '0;
        rf_raddr  <= '0;
        csr_raddr <= '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        drive_stimulus();
        for (int n = 0; n < TEST_CYCLES; n++) begin
            @(negedge clk);
            compare_outputs();
            @(posedge clk);
            step_model();
            drive_stimulus();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
cpu_pkg.sv
commit_regfile.sv
commit_arbiter.sv
trap_csr.sv
stable_timer.sv
redirect_fsm.sv
cpu_commit_top.sv
cpu_commit_properties.sv
tb_cpu_commit.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_cpu_commit -f all.f -o sim_cpu_commit \
    && ./obj_dir/sim_cpu_commit > sim.log 2>&1 \
    || echo "Regression failed" >> sim.log
grep -q "Regression failed" sim.log && { echo "FAIL: see sim.log"; exit 1; } || echo "PASS"
